/* ssc_pkg.sv */
// modulation constants and the period type shared by the spread-spectrum clock blocks
package ssc_pkg;

    // width of a half-period count value
    localparam int period_width = 4;

    typedef logic [period_width-1:0] period_t;

    // period used with spread off and after reset
    localparam period_t nominal_period = period_t'(8);

    // max spread of 7 keeps the period within 1 to 15
    localparam int spread_width = 3;

    // toggle counter in the period monitor
    localparam int count_width = 16;

endpackage

/* ssc_wb_pkg.sv */
// Wishbone bus widths and register map of the spread-spectrum clock register block
package ssc_wb_pkg;

    localparam int wb_data_width = 32;

    // word address
    localparam int wb_addr_width = 2;

    // bit 0 enable_spread, bits 3:1 spread_amount
    localparam logic [wb_addr_width-1:0] addr_ctrl = 2'd0;

    // bits 3:0 period, bit 4 direction
    localparam logic [wb_addr_width-1:0] addr_status = 2'd1;

    // bits 3:0 min half, bits 7:4 max half, a write clears the monitor
    localparam logic [wb_addr_width-1:0] addr_minmax = 2'd2;

    // bits 15:0 toggle count
    localparam logic [wb_addr_width-1:0] addr_count = 2'd3;

endpackage

/* ssc_regs.sv */
// Wishbone classic slave with the spread control register and the status and monitor readback
`timescale 1ns/100ps

module ssc_regs
    import ssc_pkg::*;
    import ssc_wb_pkg::*;
(
    input  logic                     clock_in,
    input  logic                     reset,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [wb_addr_width-1:0] wb_adr,
    input  logic [wb_data_width-1:0] wb_dat_w,
    output logic [wb_data_width-1:0] wb_dat_r,
    output logic                     wb_ack,
    input  period_t                  period,
    input  logic                     direction,
    input  period_t                  min_half,
    input  period_t                  max_half,
    input  logic [count_width-1:0]   toggle_count,
    output logic                     enable_spread,
    output logic [spread_width-1:0]  spread_amount,
    output logic                     monitor_clear
);

    logic                     bus_req;
    logic                     bus_write;
    logic [wb_data_width-1:0] read_mux;

    // new cycle seen, ack not yet given
    assign bus_req   = wb_cyc & wb_stb & ~wb_ack;
    assign bus_write = bus_req & wb_we;

    always_comb begin
        read_mux = '0;
        case (wb_adr)
            addr_ctrl: begin
                read_mux = wb_data_width'({spread_amount, enable_spread});
            end
            addr_status: begin
                read_mux = wb_data_width'({direction, period});
            end
            addr_minmax: begin
                read_mux = wb_data_width'({max_half, min_half});
            end
            addr_count: begin
                read_mux = wb_data_width'(toggle_count);
            end
            default: begin
                read_mux = '0;
            end
        endcase
    end

    always_ff @(posedge clock_in or posedge reset) begin
        if (reset) begin
            wb_ack        <= 1'b0;
            enable_spread <= 1'b0;
            spread_amount <= '0;
            monitor_clear <= 1'b0;
        end else begin
            wb_ack        <= bus_req;
            monitor_clear <= bus_write && (wb_adr == addr_minmax);
            if (bus_write && (wb_adr == addr_ctrl)) begin
                enable_spread <= wb_dat_w[0];
                spread_amount <= wb_dat_w[spread_width:1];
            end
        end
    end

    // read data only matters while ack is high
    always_ff @(posedge clock_in) begin
        if (bus_req) begin
            wb_dat_r <= read_mux;
        end
    end

endmodule

/* ssc_profile.sv */
// triangle profile that steps the divider period by one at each half-period boundary
`timescale 1ns/100ps

module ssc_profile
    import ssc_pkg::*;
(
    input  logic                    clock_in,
    input  logic                    reset,
    input  logic                    enable_spread,
    input  logic [spread_width-1:0] spread_amount,
    input  logic                    half_done,
    output period_t                 period,
    output logic                    direction
);

    period_t upper_bound;
    period_t lower_bound;

    // nominal +/- spread stays within 1 to 15
    assign upper_bound = nominal_period + period_t'(spread_amount);
    assign lower_bound = nominal_period - period_t'(spread_amount);

    // direction 1 is up, 0 is down
    always_ff @(posedge clock_in or posedge reset) begin
        if (reset) begin
            period    <= nominal_period;
            direction <= 1'b0;
        end else if (half_done) begin
            if (!enable_spread) begin
                period <= nominal_period;
            end else if (direction) begin
                if (period < upper_bound) begin
                    period <= period + period_t'(1);
                end else begin
                    // at or past the top, turn around
                    direction <= 1'b0;
                end
            end else begin
                if (period > lower_bound) begin
                    period <= period - period_t'(1);
                end else begin
                    direction <= 1'b1;
                end
            end
        end
    end

endmodule

/* ssc_divider.sv */
// clock divider that toggles clock_out every period+1 input cycles and flags each half-period end
`timescale 1ns/100ps

module ssc_divider
    import ssc_pkg::*;
(
    input  logic    clock_in,
    input  logic    reset,
    input  period_t period,
    output logic    clock_out,
    output logic    half_done
);

    period_t count;
    period_t active_period;

    // terminal count of the half period in progress
    assign half_done = (count == active_period);

    always_ff @(posedge clock_in or posedge reset) begin
        if (reset) begin
            count         <= '0;
            clock_out     <= 1'b0;
            active_period <= nominal_period;
        end else if (half_done) begin
            count     <= '0;
            clock_out <= ~clock_out;
            // next half runs on the period seen at this boundary
            active_period <= period;
        end else begin
            count <= count + period_t'(1);
        end
    end

endmodule

/* ssc_period_monitor.sv */
// measures each half period of clock_out and keeps the minimum, maximum and toggle count
`timescale 1ns/100ps

module ssc_period_monitor
    import ssc_pkg::*;
(
    input  logic                   clock_in,
    input  logic                   reset,
    input  logic                   half_done,
    input  logic                   monitor_clear,
    output period_t                min_half,
    output period_t                max_half,
    output logic [count_width-1:0] toggle_count
);

    // cycles since the last half_done, held at 15
    period_t half_len;
    logic    started;

    always_ff @(posedge clock_in or posedge reset) begin
        if (reset) begin
            half_len     <= '0;
            started      <= 1'b0;
            min_half     <= '1;
            max_half     <= '0;
            toggle_count <= '0;
        end else if (monitor_clear) begin
            half_len     <= '0;
            started      <= 1'b0;
            min_half     <= '1;
            max_half     <= '0;
            toggle_count <= '0;
        end else if (half_done) begin
            half_len <= period_t'(1);
            started  <= 1'b1;
            if (toggle_count != '1) begin
                toggle_count <= toggle_count + count_width'(1);
            end
            // first boundary only opens the measurement
            if (started) begin
                if (half_len < min_half) begin
                    min_half <= half_len;
                end
                if (half_len > max_half) begin
                    max_half <= half_len;
                end
            end
        end else if (half_len != '1) begin
            half_len <= half_len + period_t'(1);
        end
    end

endmodule

/* ssc_top.sv */
// top level of the spread-spectrum clock, Wishbone register block plus profile, divider and monitor
`timescale 1ns/100ps

module ssc_top
    import ssc_pkg::*;
    import ssc_wb_pkg::*;
(
    input  logic                     clock_in,
    input  logic                     reset,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [wb_addr_width-1:0] wb_adr,
    input  logic [wb_data_width-1:0] wb_dat_w,
    output logic [wb_data_width-1:0] wb_dat_r,
    output logic                     wb_ack,
    output logic                     clock_out
);

    logic                    enable_spread;
    logic [spread_width-1:0] spread_amount;
    logic                    monitor_clear;
    period_t                 period;
    logic                    direction;
    logic                    half_done;
    period_t                 min_half;
    period_t                 max_half;
    logic [count_width-1:0]  toggle_count;

    ssc_regs ssc_regs_i (
        .clock_in      (clock_in),
        .reset         (reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .period        (period),
        .direction     (direction),
        .min_half      (min_half),
        .max_half      (max_half),
        .toggle_count  (toggle_count),
        .enable_spread (enable_spread),
        .spread_amount (spread_amount),
        .monitor_clear (monitor_clear)
    );

    ssc_profile ssc_profile_i (
        .clock_in      (clock_in),
        .reset         (reset),
        .enable_spread (enable_spread),
        .spread_amount (spread_amount),
        .half_done     (half_done),
        .period        (period),
        .direction     (direction)
    );

    ssc_divider ssc_divider_i (
        .clock_in  (clock_in),
        .reset     (reset),
        .period    (period),
        .clock_out (clock_out),
        .half_done (half_done)
    );

    ssc_period_monitor ssc_period_monitor_i (
        .clock_in      (clock_in),
        .reset         (reset),
        .half_done     (half_done),
        .monitor_clear (monitor_clear),
        .min_half      (min_half),
        .max_half      (max_half),
        .toggle_count  (toggle_count)
    );

endmodule

/* ssc_tb.sv */
// testbench for the spread-spectrum clock, replays bus accesses and waits listed in ssc_tests.txt
`timescale 1ns/100ps

module ssc_tb
    import ssc_wb_pkg::*;
();

    logic                     clock_in;
    logic                     reset;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [wb_addr_width-1:0] wb_adr;
    logic [wb_data_width-1:0] wb_dat_w;
    logic [wb_data_width-1:0] wb_dat_r;
    logic                     wb_ack;
    logic                     clock_out;

    // one entry per test line
    logic [7:0]  op_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] data_q[$];
    logic [31:0] exp_q[$];

    bit load_ok;
    bit limit_ready;
    bit test_open;
    int timeout_limit;
    int cycle_count;
    int error_count;
    int check_count;
    int test_errors;
    int test_id;
    int pass_tests;
    int fail_tests;

    // half periods of clock_out since the last minmax write
    logic        last_clock_out;
    bit          half_open;
    int          half_cycles;
    int          seen_min;
    int          seen_max;
    logic [31:0] measured_minmax;

    ssc_top ssc_top_i (
        .clock_in  (clock_in),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .clock_out (clock_out)
    );

    initial begin
        clock_in = 1'b0;
        forever begin
            #4 clock_in = ~clock_in;
        end
    end

    always @(posedge clock_in) begin
        cycle_count <= cycle_count + 1;
        if (limit_ready && cycle_count >= timeout_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic clear_measure();
        half_open   = 1'b0;
        half_cycles = 0;
        seen_min    = 15;
        seen_max    = 0;
    endtask

    // length of each clock_out half in clock_in cycles, 16 held at 15
    always @(posedge clock_in) begin
        if (reset) begin
            last_clock_out = 1'b0;
            clear_measure();
        end else if (clock_out !== last_clock_out) begin
            last_clock_out = clock_out;
            if (half_open) begin
                if (half_cycles > 15) begin
                    half_cycles = 15;
                end
                if (half_cycles < seen_min) begin
                    seen_min = half_cycles;
                end
                if (half_cycles > seen_max) begin
                    seen_max = half_cycles;
                end
            end
            half_open   = 1'b1;
            half_cycles = 1;
        end else begin
            half_cycles++;
        end
    end

    task automatic load_tests();
        int               fd;
        int               fields;
        logic [8*128-1:0] line_buf;
        logic [63:0]      op_text;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      expected;
        fd = $fopen("ssc_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file ssc_tests.txt");
            load_ok = 1'b0;
        end else begin
            load_ok  = 1'b1;
            line_buf = '0;
            while ($fgets(line_buf, fd) != 0) begin
                op_text = '0;
                fields  = $sscanf(line_buf, "%s %h %h %h", op_text, addr, data, expected);
                // comment and blank lines fall out here
                if (fields == 4 && op_text[7:0] != "#") begin
                    op_q.push_back(op_text[7:0]);
                    addr_q.push_back(addr);
                    data_q.push_back(data);
                    exp_q.push_back(expected);
                end
                line_buf = '0;
            end
            $fclose(fd);
        end
    endtask

    // reset cycles, all waits, and 20 cycles per bus access
    function automatic int cycle_budget();
        int total;
        total = 5;
        foreach (op_q[i]) begin
            if (op_q[i] == "D") begin
                total += int'(data_q[i]);
            end else if (op_q[i] != "T") begin
                total += 20;
            end
        end
        return total;
    endfunction

    // all-ones mask as wide as the upper bound
    function automatic logic [31:0] field_mask(input logic [31:0] upper);
        logic [31:0] mask;
        mask = upper;
        mask = mask | (mask >> 1);
        mask = mask | (mask >> 2);
        mask = mask | (mask >> 4);
        mask = mask | (mask >> 8);
        mask = mask | (mask >> 16);
        return mask;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, read %h, expected %h", $time, what, actual, expected);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic bus_cycle(input logic write, input logic [31:0] addr,
                             input logic [31:0] data, output logic [31:0] rdata);
        int idle;
        int waited;
        bit acked;
        idle  = $urandom_range(3, 0);
        rdata = '0;
        acked = 1'b0;
        repeat (idle) @(posedge clock_in);
        @(posedge clock_in);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= write;
        wb_adr   <= addr[wb_addr_width-1:0];
        wb_dat_w <= data;
        // sample ack away from the driving edge
        for (waited = 0; waited < 4 && !acked; waited++) begin
            @(negedge clock_in);
            if (wb_ack) begin
                acked           = 1'b1;
                rdata           = wb_dat_r;
                measured_minmax = 32'(seen_max * 16 + seen_min);
                if (write && addr[wb_addr_width-1:0] == addr_minmax) begin
                    clear_measure();
                end
            end
        end
        @(posedge clock_in);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!acked) begin
            $display("at %0t ns the slave did not acknowledge the access to address %0h",
                     $time, addr);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_open) begin
            if (test_errors == 0) begin
                pass_tests++;
                $display("test %0d passed", test_id);
            end else begin
                fail_tests++;
                $display("test %0d failed with %0d errors", test_id, test_errors);
            end
            test_open = 1'b0;
        end
    endtask

    task automatic run_tests();
        int          i;
        logic [31:0] rdata;
        logic [31:0] mask;
        logic        in_range;
        for (i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "T": begin
                    finish_test();
                    test_id     = int'(data_q[i]);
                    test_errors = 0;
                    test_open   = 1'b1;
                end
                "W": begin
                    bus_cycle(1'b1, addr_q[i], data_q[i], rdata);
                end
                "R": begin
                    bus_cycle(1'b0, addr_q[i], 32'd0, rdata);
                    check_value(rdata, exp_q[i], $sformatf("read of address %0h", addr_q[i]));
                    // clock_out itself has to show the same extremes
                    if (addr_q[i][wb_addr_width-1:0] == addr_minmax) begin
                        check_value(measured_minmax, exp_q[i], "half periods of clock_out");
                    end
                end
                "B": begin
                    bus_cycle(1'b0, addr_q[i], 32'd0, rdata);
                    mask     = field_mask(exp_q[i]);
                    in_range = ((rdata & mask) >= data_q[i]) && ((rdata & mask) <= exp_q[i]);
                    check_value({31'd0, in_range}, 32'd1,
                                $sformatf("field %0h of address %0h outside %0h to %0h",
                                          rdata & mask, addr_q[i], data_q[i], exp_q[i]));
                end
                "D": begin
                    repeat (data_q[i]) @(posedge clock_in);
                end
                default: begin
                    $display("unknown operation %s in the test file", op_q[i]);
                    error_count++;
                end
            endcase
        end
        finish_test();
    endtask

    initial begin
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        void'($urandom(32'h3c62_bf07));
        load_tests();
        timeout_limit = cycle_budget();
        limit_ready   = 1'b1;
        repeat (5) @(posedge clock_in);
        reset <= 1'b0;
        if (load_ok) begin
            run_tests();
        end
        repeat (2) @(posedge clock_in);
        $display("%0d tests passed, %0d tests failed", pass_tests, fail_tests);
        if (load_ok && check_count > 0 && error_count == 0 && fail_tests == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* ssc_tests.txt */
# op addr data expected, all hex; T starts test number data, W writes, R reads and compares
# D waits data cycles; B reads and checks the field as wide as expected lies in data..expected
T 0 1 0
R 3 0 0
R 2 0 f
R 0 0 0
R 1 0 8
T 0 2 0
W 2 0 0
D 0 c8 0
R 2 0 99
B 3 1 ffff
T 0 3 0
W 0 7 0
W 2 0 0
D 0 190 0
R 2 0 c6
B 1 5 b
T 0 4 0
W 0 f 0
W 2 0 0
D 0 258 0
R 2 0 f2
T 0 5 0
W 0 0 0
D 0 64 0
B 1 8 8
W 2 0 0
D 0 c8 0
R 2 0 99
T 0 6 0
W 0 ffffffff 0
R 0 0 f
W 0 a 0
R 0 0 a
W 0 0 0
D 0 64 0
W 2 0 0
R 2 0 f

/* files.f */
ssc_pkg.sv
ssc_wb_pkg.sv
ssc_regs.sv
ssc_profile.sv
ssc_divider.sv
ssc_period_monitor.sv
ssc_top.sv
ssc_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary -j 0 --top-module ssc_tb -f files.f -o ssc_sim
	./obj_dir/ssc_sim | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
